// ==== design/periph_pkg.sv ====
// Widths, address layout and register map shared by the peripheral subsystem blocks
`default_nettype none

package periph_pkg;

    localparam int ADDR_W  = 12;
    localparam int DATA_W  = 32;
    localparam int IDX_W   = 8;
    localparam int NUM_SRC = 8;    // Id 0 reserved
    localparam int NUM_TGT = 2;
    localparam int NUM_EXT = 5;    // Ids 3 to 7
    localparam int NUM_TMR = 2;    // Ids 1 and 2
    localparam int PRIO_W  = 3;
    localparam int ID_W    = 3;

    // Regions 2 and 3 are unmapped
    localparam logic [1:0] REGION_PLIC = 2'd0;
    localparam logic [1:0] REGION_TMR  = 2'd1;

    typedef struct packed {
        logic [1:0]       region;
        logic [IDX_W-1:0] index;
        logic [1:0]       offset;    // Byte within the word
    } periph_addr_s;

    typedef union packed {
        logic [ADDR_W-1:0] word;
        periph_addr_s      f;
    } periph_addr_u;

    // PLIC word indexes
    localparam logic [IDX_W-1:0] PRIO_BASE      = 8'd0;     // One per id
    localparam logic [IDX_W-1:0] PENDING_IDX    = 8'd8;
    localparam logic [IDX_W-1:0] ENABLE_BASE    = 8'd16;    // Plus target
    localparam logic [IDX_W-1:0] THRESH_BASE    = 8'd24;
    localparam logic [IDX_W-1:0] CLAIM_BASE     = 8'd28;

    // Timer word indexes
    localparam logic [IDX_W-1:0] TMR_CTRL_IDX   = 8'd0;
    localparam logic [IDX_W-1:0] TMR_STATUS_IDX = 8'd1;
    localparam logic [IDX_W-1:0] TMR_CMP_BASE   = 8'd2;     // Plus channel
    localparam logic [IDX_W-1:0] TMR_CNT_BASE   = 8'd4;

endpackage

`default_nettype wire

// ==== design/reg_bus_if.sv ====
// Single-cycle register access channel from the region decoder to one register block
`default_nettype none

interface reg_bus_if;

    logic                          req;      // One-cycle strobe
    logic                          we;
    logic [periph_pkg::IDX_W-1:0]  idx;      // Word index inside the region
    logic [periph_pkg::DATA_W-1:0] wdata;
    logic [periph_pkg::DATA_W-1:0] rdata;    // Valid in the req cycle
    logic                          ack;

    modport decoder (
        output req, we, idx, wdata,
        input  rdata, ack
    );

    modport block (
        input  req, we, idx, wdata,
        output rdata, ack
    );

endinterface

`default_nettype wire

// ==== design/wb_region_decoder.sv ====
// Wishbone classic slave that routes each access to a register region or answers with an error
`default_nettype none

module wb_region_decoder (
    input  logic                          clk_i,
    input  logic                          reset_i,
    input  logic                          wb_cyc_i,
    input  logic                          wb_stb_i,
    input  logic                          wb_we_i,
    input  periph_pkg::periph_addr_u      wb_adr_i,
    input  logic [periph_pkg::DATA_W-1:0] wb_dat_i,
    output logic [periph_pkg::DATA_W-1:0] wb_dat_o,
    output logic                          wb_ack_o,
    output logic                          wb_err_o,
    reg_bus_if.decoder                    tmr_bus,
    reg_bus_if.decoder                    plic_bus
);

    logic                          start;
    logic                          sel_tmr;
    logic                          sel_plic;
    logic                          ack_q;
    logic                          err_q;
    logic [periph_pkg::DATA_W-1:0] rdata;
    logic [periph_pkg::DATA_W-1:0] dat_q;

    // No new access in the cycle that carries a response
    assign start    = wb_cyc_i && wb_stb_i && !(ack_q || err_q);
    assign sel_tmr  = wb_adr_i.f.region == periph_pkg::REGION_TMR;
    assign sel_plic = wb_adr_i.f.region == periph_pkg::REGION_PLIC;

    assign tmr_bus.req    = start && sel_tmr;
    assign tmr_bus.we     = wb_we_i;
    assign tmr_bus.idx    = wb_adr_i.f.index;
    assign tmr_bus.wdata  = wb_dat_i;
    assign plic_bus.req   = start && sel_plic;
    assign plic_bus.we    = wb_we_i;
    assign plic_bus.idx   = wb_adr_i.f.index;
    assign plic_bus.wdata = wb_dat_i;

    assign rdata = sel_tmr ? tmr_bus.rdata : (sel_plic ? plic_bus.rdata : '0);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ack_q <= 1'b0;
            err_q <= 1'b0;
        end else begin
            ack_q <= tmr_bus.ack || plic_bus.ack;
            err_q <= start && !(sel_tmr || sel_plic);    // Unmapped region
        end
    end

    always_ff @(posedge clk_i) begin
        dat_q <= (start && !wb_we_i) ? rdata : '0;
    end

    assign wb_dat_o = dat_q;
    assign wb_ack_o = ack_q;
    assign wb_err_o = err_q;

    // ----------------------------------------------------------
    // Response rules
    // ----------------------------------------------------------
    assert property (@(posedge clk_i) disable iff (reset_i)
        !(wb_ack_o && wb_err_o));
    assert property (@(posedge clk_i) disable iff (reset_i)
        (wb_ack_o || wb_err_o) |=> !(wb_ack_o || wb_err_o));
    assert property (@(posedge clk_i) disable iff (reset_i)
        (tmr_bus.ack == tmr_bus.req) && (plic_bus.ack == plic_bus.req));

endmodule

`default_nettype wire

// ==== design/cmp_timer.sv ====
// Two-channel compare timer register block that raises one level interrupt per match flag
`default_nettype none

module cmp_timer (
    input  logic                           clk_i,
    input  logic                           reset_i,
    reg_bus_if.block                       bus,
    output logic [periph_pkg::NUM_TMR-1:0] tmr_irq_o
);

    logic [periph_pkg::NUM_TMR-1:0] ctrl_q;    // Channel enables
    logic [periph_pkg::NUM_TMR-1:0] flag_q;    // Match flags
    logic [periph_pkg::NUM_TMR-1:0] match;
    logic [periph_pkg::DATA_W-1:0]  cmp_q [periph_pkg::NUM_TMR];
    logic [periph_pkg::DATA_W-1:0]  cnt_q [periph_pkg::NUM_TMR];
    logic                           wr;
    logic                           ch;
    logic                           ctrl_sel;
    logic                           stat_sel;
    logic                           cmp_sel;
    logic                           cnt_sel;

    assign wr       = bus.req && bus.we;
    assign ch       = bus.idx[0];    // Channel inside a register pair
    assign ctrl_sel = bus.idx == periph_pkg::TMR_CTRL_IDX;
    assign stat_sel = bus.idx == periph_pkg::TMR_STATUS_IDX;
    assign cmp_sel  = (bus.idx >> 1) == (periph_pkg::TMR_CMP_BASE >> 1);
    assign cnt_sel  = (bus.idx >> 1) == (periph_pkg::TMR_CNT_BASE >> 1);
    assign bus.ack  = bus.req;

    always_comb begin
        for (int c = 0; c < periph_pkg::NUM_TMR; c++) begin
            match[c] = ctrl_q[c] && (cnt_q[c] == cmp_q[c]);
        end
    end

    // ----------------------------------------------------------
    // Register read
    // ----------------------------------------------------------
    always_comb begin
        bus.rdata = '0;
        if (ctrl_sel) begin
            bus.rdata[periph_pkg::NUM_TMR-1:0] = ctrl_q;
        end else if (stat_sel) begin
            bus.rdata[periph_pkg::NUM_TMR-1:0] = flag_q;
        end else if (cmp_sel) begin
            bus.rdata = cmp_q[ch];
        end else if (cnt_sel) begin
            bus.rdata = cnt_q[ch];
        end
    end

    // ----------------------------------------------------------
    // Counters and flags
    // ----------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            ctrl_q <= '0;
            flag_q <= '0;
            for (int c = 0; c < periph_pkg::NUM_TMR; c++) begin
                cnt_q[c] <= '0;
            end
        end else begin
            if (wr && ctrl_sel) begin
                ctrl_q <= bus.wdata[periph_pkg::NUM_TMR-1:0];
            end
            for (int c = 0; c < periph_pkg::NUM_TMR; c++) begin
                if (wr && cnt_sel && ch == c[0]) begin
                    cnt_q[c] <= bus.wdata;
                end else if (match[c]) begin
                    cnt_q[c] <= '0;              // Wrap on compare
                end else if (ctrl_q[c]) begin
                    cnt_q[c] <= cnt_q[c] + 1'b1;
                end
                if (match[c]) begin
                    flag_q[c] <= 1'b1;           // A new match beats the clear
                end else if (wr && stat_sel && bus.wdata[c]) begin
                    flag_q[c] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (wr && cmp_sel) begin
            cmp_q[ch] <= bus.wdata;
        end
    end

    assign tmr_irq_o = flag_q;

endmodule

`default_nettype wire

// ==== design/irq_gateway.sv ====
// Interrupt gateway holding pending and in-service state per source id for the PLIC targets
`default_nettype none

module irq_gateway (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic [periph_pkg::NUM_SRC-1:0] src_i,
    input  logic                           claim_valid_i,
    input  logic [periph_pkg::ID_W-1:0]    claim_id_i,
    input  logic                           complete_valid_i,
    input  logic [periph_pkg::ID_W-1:0]    complete_id_i,
    output logic [periph_pkg::NUM_SRC-1:0] pending_o
);

    logic [periph_pkg::NUM_SRC-1:0] pending_q;
    logic [periph_pkg::NUM_SRC-1:0] active_q;    // Claimed, waiting for complete

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            pending_q <= '0;
            active_q  <= '0;
        end else begin
            // Id 0 is not a source
            for (int id = 1; id < periph_pkg::NUM_SRC; id++) begin
                if (claim_valid_i && claim_id_i == id[periph_pkg::ID_W-1:0]) begin
                    pending_q[id] <= 1'b0;
                    active_q[id]  <= 1'b1;
                end else if (src_i[id] && !active_q[id]) begin
                    pending_q[id] <= 1'b1;    // Level still high re-arms after complete
                end
                if (complete_valid_i && complete_id_i == id[periph_pkg::ID_W-1:0]) begin
                    active_q[id] <= 1'b0;
                end
            end
        end
    end

    assign pending_o = pending_q;

    // Id 0 never pending
    assert property (@(posedge clk_i) disable iff (reset_i)
        !pending_o[0]);

endmodule

`default_nettype wire

// ==== design/plic_targets.sv ====
// PLIC register block with per-target arbitration, claim and complete for two targets
`default_nettype none

module plic_targets (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic [periph_pkg::NUM_SRC-1:0] pending_i,
    reg_bus_if.block                       bus,
    output logic [periph_pkg::NUM_TGT-1:0] irq_o,
    output logic                           claim_valid_o,
    output logic [periph_pkg::ID_W-1:0]    claim_id_o,
    output logic                           complete_valid_o,
    output logic [periph_pkg::ID_W-1:0]    complete_id_o
);

    logic [periph_pkg::PRIO_W-1:0]  prio_q   [periph_pkg::NUM_SRC];
    logic [periph_pkg::NUM_SRC-1:0] enable_q [periph_pkg::NUM_TGT];
    logic [periph_pkg::PRIO_W-1:0]  thresh_q [periph_pkg::NUM_TGT];
    logic [periph_pkg::ID_W-1:0]    best_id  [periph_pkg::NUM_TGT];
    logic [periph_pkg::ID_W-1:0]    src_id;
    logic                           tgt;
    logic                           wr;
    logic                           prio_sel;
    logic                           pend_sel;
    logic                           en_sel;
    logic                           th_sel;
    logic                           claim_sel;

    assign wr        = bus.req && bus.we;
    assign src_id    = bus.idx[periph_pkg::ID_W-1:0];
    assign tgt       = bus.idx[0];
    assign prio_sel  = (bus.idx >> periph_pkg::ID_W) == (periph_pkg::PRIO_BASE >> periph_pkg::ID_W);
    assign pend_sel  = bus.idx == periph_pkg::PENDING_IDX;
    assign en_sel    = (bus.idx >> 1) == (periph_pkg::ENABLE_BASE >> 1);
    assign th_sel    = (bus.idx >> 1) == (periph_pkg::THRESH_BASE >> 1);
    assign claim_sel = (bus.idx >> 1) == (periph_pkg::CLAIM_BASE >> 1);
    assign bus.ack   = bus.req;

    // ----------------------------------------------------------
    // Arbitration with ties to the lowest id
    // ----------------------------------------------------------
    always_comb begin
        logic [periph_pkg::PRIO_W-1:0] level;
        for (int t = 0; t < periph_pkg::NUM_TGT; t++) begin
            best_id[t] = '0;
            level      = thresh_q[t];    // Must beat the threshold
            for (int id = 1; id < periph_pkg::NUM_SRC; id++) begin
                if (pending_i[id] && enable_q[t][id] && prio_q[id] > level) begin
                    best_id[t] = id[periph_pkg::ID_W-1:0];
                    level      = prio_q[id];
                end
            end
            irq_o[t] = best_id[t] != '0;
        end
    end

    always_comb begin
        bus.rdata = '0;
        if (prio_sel) begin
            bus.rdata[periph_pkg::PRIO_W-1:0] = prio_q[src_id];
        end else if (pend_sel) begin
            bus.rdata[periph_pkg::NUM_SRC-1:0] = pending_i;
        end else if (en_sel) begin
            bus.rdata[periph_pkg::NUM_SRC-1:0] = enable_q[tgt];
        end else if (th_sel) begin
            bus.rdata[periph_pkg::PRIO_W-1:0] = thresh_q[tgt];
        end else if (claim_sel) begin
            bus.rdata[periph_pkg::ID_W-1:0] = best_id[tgt];
        end
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            for (int id = 0; id < periph_pkg::NUM_SRC; id++) begin
                prio_q[id] <= '0;
            end
            for (int t = 0; t < periph_pkg::NUM_TGT; t++) begin
                enable_q[t] <= '0;
                thresh_q[t] <= '0;
            end
        end else if (wr) begin
            if (prio_sel && src_id != '0) begin
                prio_q[src_id] <= bus.wdata[periph_pkg::PRIO_W-1:0];
            end
            if (en_sel) begin
                enable_q[tgt] <= {bus.wdata[periph_pkg::NUM_SRC-1:1], 1'b0};
            end
            if (th_sel) begin
                thresh_q[tgt] <= bus.wdata[periph_pkg::PRIO_W-1:0];
            end
        end
    end

    // Claim on read, complete on write
    assign claim_valid_o    = bus.req && !bus.we && claim_sel && (best_id[tgt] != '0);
    assign claim_id_o       = best_id[tgt];
    assign complete_valid_o = wr && claim_sel;
    assign complete_id_o    = bus.wdata[periph_pkg::ID_W-1:0];

    // A claim always names a real id
    assert property (@(posedge clk_i) disable iff (reset_i)
        claim_valid_o |-> (claim_id_o != '0));

endmodule

`default_nettype wire

// ==== design/periph_top.sv ====
// Peripheral subsystem top with a Wishbone slave port, compare timer and two-target PLIC
`default_nettype none

module periph_top (
    input  logic                           clk_i,
    input  logic                           reset_i,
    input  logic                           wb_cyc_i,
    input  logic                           wb_stb_i,
    input  logic                           wb_we_i,
    input  logic [periph_pkg::ADDR_W-1:0]  wb_adr_i,
    input  logic [periph_pkg::DATA_W-1:0]  wb_dat_i,
    output logic [periph_pkg::DATA_W-1:0]  wb_dat_o,
    output logic                           wb_ack_o,
    output logic                           wb_err_o,
    input  logic [periph_pkg::NUM_EXT-1:0] ext_irq_i,
    output logic [periph_pkg::NUM_TGT-1:0] irq_o
);

    logic [periph_pkg::NUM_TMR-1:0] tmr_irq;
    logic [periph_pkg::NUM_SRC-1:0] irq_src;
    logic [periph_pkg::NUM_SRC-1:0] pending;
    logic                           claim_valid;
    logic [periph_pkg::ID_W-1:0]    claim_id;
    logic                           complete_valid;
    logic [periph_pkg::ID_W-1:0]    complete_id;

    reg_bus_if tmr_bus ();
    reg_bus_if plic_bus ();

    // Id 0 unused, timers on 1 and 2, external lines on 3 to 7
    assign irq_src = {ext_irq_i, tmr_irq, 1'b0};

    wb_region_decoder i_decoder (
        .clk_i    ( clk_i    ),
        .reset_i  ( reset_i  ),
        .wb_cyc_i ( wb_cyc_i ),
        .wb_stb_i ( wb_stb_i ),
        .wb_we_i  ( wb_we_i  ),
        .wb_adr_i ( wb_adr_i ),
        .wb_dat_i ( wb_dat_i ),
        .wb_dat_o ( wb_dat_o ),
        .wb_ack_o ( wb_ack_o ),
        .wb_err_o ( wb_err_o ),
        .tmr_bus  ( tmr_bus  ),
        .plic_bus ( plic_bus )
    );

    cmp_timer i_timer (
        .clk_i     ( clk_i   ),
        .reset_i   ( reset_i ),
        .bus       ( tmr_bus ),
        .tmr_irq_o ( tmr_irq )
    );

    irq_gateway i_gateway (
        .clk_i            ( clk_i          ),
        .reset_i          ( reset_i        ),
        .src_i            ( irq_src        ),
        .claim_valid_i    ( claim_valid    ),
        .claim_id_i       ( claim_id       ),
        .complete_valid_i ( complete_valid ),
        .complete_id_i    ( complete_id    ),
        .pending_o        ( pending        )
    );

    plic_targets i_targets (
        .clk_i            ( clk_i          ),
        .reset_i          ( reset_i        ),
        .pending_i        ( pending        ),
        .bus              ( plic_bus       ),
        .irq_o            ( irq_o          ),
        .claim_valid_o    ( claim_valid    ),
        .claim_id_o       ( claim_id       ),
        .complete_valid_o ( complete_valid ),
        .complete_id_o    ( complete_id    )
    );

endmodule

`default_nettype wire

// ==== verification/tb_periph_model.svh ====
// Wishbone master tasks and the PLIC reference model that the testbench module includes
`ifndef TB_PERIPH_MODEL_SVH
`define TB_PERIPH_MODEL_SVH

logic [2:0] model_prio   [8];
logic [7:0] model_enable [2];
logic [2:0] model_thresh [2];
logic [7:0] model_pending;
logic [7:0] model_active;    // Claimed, not yet completed
logic       last_ack;
logic       last_err;

function automatic logic [11:0] reg_addr(input logic [1:0] region, input int idx);
    return {region, idx[7:0], 2'b00};
endfunction

// ----------------------------------------------------------
// Wishbone master
// ----------------------------------------------------------
task automatic bus_cycle(input logic we, input logic [11:0] adr, input logic [31:0] wdat,
                         output logic [31:0] rdat);
    int waited;
    waited   = 0;
    rdat     = '0;
    last_ack = 1'b0;
    last_err = 1'b0;
    wb_cyc_i = 1'b1;
    wb_stb_i = 1'b1;
    wb_we_i  = we;
    wb_adr_i = adr;
    wb_dat_i = wdat;
    while (!(wb_ack_o || wb_err_o) && waited < 20) begin
        @(posedge clk_i);
        #1;
        waited++;
    end
    if (wb_ack_o || wb_err_o) begin
        last_ack = wb_ack_o;
        last_err = wb_err_o;
        rdat     = wb_dat_o;
    end else begin
        $display("Timeout at %0t: no Wishbone response for address %h", $time, adr);
        fail_count++;
    end
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    @(posedge clk_i);    // Strobe low for one cycle
    #1;
endtask

task automatic wb_write(input logic [11:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, wdat, unused);
endtask

task automatic wb_read(input logic [11:0] adr, output logic [31:0] rdat);
    bus_cycle(1'b0, adr, '0, rdat);
endtask

// ----------------------------------------------------------
// PLIC model
// ----------------------------------------------------------
function automatic logic [2:0] expected_claim(input int t);
    logic [2:0] best;
    logic [2:0] level;
    best  = '0;
    level = model_thresh[t];
    for (int id = 1; id < 8; id++) begin
        if (model_pending[id] && model_enable[t][id] && model_prio[id] > level) begin
            best  = id[2:0];
            level = model_prio[id];    // Equal priority keeps the lower id
        end
    end
    return best;
endfunction

// External line e is id e+3
function automatic void latch_pending(input logic [4:0] lines);
    for (int e = 0; e < 5; e++) begin
        if (lines[e] && !model_active[e+3]) begin
            model_pending[e+3] = 1'b1;
        end
    end
endfunction

task automatic claim_and_check(input int t, output logic [2:0] id);
    logic [31:0] rd;
    logic [2:0]  exp;
    exp = expected_claim(t);
    wb_read(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::CLAIM_BASE + t), rd);
    check_value($sformatf("claim of target %0d", t), rd, 32'(exp));
    if (exp != 3'd0) begin
        model_pending[exp] = 1'b0;
        model_active[exp]  = 1'b1;
    end
    id = exp;
endtask

task automatic complete_id(input int t, input logic [2:0] id);
    wb_write(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::CLAIM_BASE + t), 32'(id));
    model_active[id] = 1'b0;
    latch_pending(ext_irq_i);
endtask

`endif

// ==== verification/tb_periph.sv ====
// Testbench top that drives random bus and interrupt stimulus and checks it against a model
`default_nettype none

module tb_periph;

    timeunit 1ns;
    timeprecision 100ps;

    logic        clk_i;
    logic        reset_i;
    logic        wb_cyc_i;
    logic        wb_stb_i;
    logic        wb_we_i;
    logic [11:0] wb_adr_i;
    logic [31:0] wb_dat_i;
    logic [31:0] wb_dat_o;
    logic        wb_ack_o;
    logic        wb_err_o;
    logic [4:0]  ext_irq_i;
    logic [1:0]  irq_o;
    int          seed;
    int          pass_count;
    int          fail_count;

    `include "tb_periph_model.svh"

    periph_top UUT (
        .clk_i     ( clk_i     ),
        .reset_i   ( reset_i   ),
        .wb_cyc_i  ( wb_cyc_i  ),
        .wb_stb_i  ( wb_stb_i  ),
        .wb_we_i   ( wb_we_i   ),
        .wb_adr_i  ( wb_adr_i  ),
        .wb_dat_i  ( wb_dat_i  ),
        .wb_dat_o  ( wb_dat_o  ),
        .wb_ack_o  ( wb_ack_o  ),
        .wb_err_o  ( wb_err_o  ),
        .ext_irq_i ( ext_irq_i ),
        .irq_o     ( irq_o     )
    );

    always #2 clk_i = ~clk_i;

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) begin
            pass_count++;
        end else begin
            $display("FAILED %0t: %s is %h, expected %h", $time, what, got, exp);
            fail_count++;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errs_before);
        $display("test %0d (%s) done, %0d errors", num, name, fail_count - errs_before);
    endtask

    initial begin
        logic [31:0] data;
        logic [31:0] rd;
        logic [31:0] exp;
        logic [11:0] adr;
        logic [2:0]  id;
        logic [2:0]  id2;
        int          errs;
        int          waited;
        clk_i      = 1'b0;
        reset_i    = 1'b1;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        ext_irq_i  = '0;
        seed       = 32'hd850;
        pass_count = 0;
        fail_count = 0;
        model_pending = '0;
        model_active  = '0;
        for (int i = 0; i < 8; i++) begin
            model_prio[i] = '0;
        end
        for (int t = 0; t < 2; t++) begin
            model_enable[t] = '0;
            model_thresh[t] = '0;
        end
        repeat (8) @(posedge clk_i);
        #1;
        reset_i = 1'b0;

        // ----------------------------------------------------------
        // Reset state
        // ----------------------------------------------------------
        errs = fail_count;
        check_value("irq_o", 32'(irq_o), 32'h0);
        for (int i = 0; i < 8; i++) begin
            wb_read(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::PRIO_BASE + i), rd);
            check_value($sformatf("priority %0d", i), rd, 32'h0);
        end
        for (int t = 0; t < 2; t++) begin
            wb_read(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::ENABLE_BASE + t), rd);
            check_value("enable", rd, 32'h0);
            wb_read(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::THRESH_BASE + t), rd);
            check_value("threshold", rd, 32'h0);
        end
        wb_read(reg_addr(periph_pkg::REGION_TMR, periph_pkg::TMR_STATUS_IDX), rd);
        check_value("timer status", rd, 32'h0);
        report_test(1, "reset values", errs);

        // ----------------------------------------------------------
        // Register write and read back
        // ----------------------------------------------------------
        errs = fail_count;
        for (int i = 0; i < 24; i++) begin
            rd   = $random(seed);
            data = $random(seed);
            case (rd[1:0])
                2'd0: begin
                    adr = reg_addr(periph_pkg::REGION_PLIC, periph_pkg::PRIO_BASE + rd[4:2]);
                    exp = (rd[4:2] == 3'd0) ? 32'h0 : 32'(data[2:0]);  // Id 0 has no priority
                    model_prio[rd[4:2]] = exp[2:0];
                end
                2'd1: begin
                    adr = reg_addr(periph_pkg::REGION_PLIC, periph_pkg::ENABLE_BASE + rd[2]);
                    exp = 32'(data[7:0] & 8'hfe);
                    model_enable[rd[2]] = exp[7:0];
                end
                2'd2: begin
                    adr = reg_addr(periph_pkg::REGION_PLIC, periph_pkg::THRESH_BASE + rd[2]);
                    exp = 32'(data[2:0]);
                    model_thresh[rd[2]] = exp[2:0];
                end
                default: begin
                    adr = reg_addr(periph_pkg::REGION_TMR, periph_pkg::TMR_CMP_BASE + rd[2]);
                    exp = data;
                end
            endcase
            wb_write(adr, data);
            check_value("ack on mapped write", 32'(last_ack), 32'h1);
            wb_read(adr, rd);
            check_value($sformatf("register at %h", adr), rd, exp);
        end
        wb_write(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::PENDING_IDX), $random(seed));
        wb_read(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::PENDING_IDX), rd);
        check_value("pending after write", rd, 32'(model_pending));
        report_test(2, "register read back", errs);

        // ----------------------------------------------------------
        // Unmapped regions
        // ----------------------------------------------------------
        errs = fail_count;
        for (int r = 2; r < 4; r++) begin
            adr = reg_addr(r[1:0], $random(seed));
            wb_write(adr, $random(seed));
            check_value("err on write", 32'(last_err), 32'h1);
            check_value("ack on write", 32'(last_ack), 32'h0);
            wb_read(adr, rd);
            check_value("err on read", 32'(last_err), 32'h1);
            check_value("ack on read", 32'(last_ack), 32'h0);
            check_value("unmapped read data", rd, 32'h0);
        end
        report_test(3, "unmapped regions", errs);

        // ----------------------------------------------------------
        // External lines, arbitration, claim and complete
        // ----------------------------------------------------------
        errs = fail_count;
        for (int r = 0; r < 8; r++) begin
            for (int i = 1; i < 8; i++) begin
                data = $random(seed);
                wb_write(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::PRIO_BASE + i), data);
                model_prio[i] = data[2:0];
            end
            for (int t = 0; t < 2; t++) begin
                data = $random(seed);
                wb_write(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::ENABLE_BASE + t), data);
                model_enable[t] = data[7:0] & 8'hfe;
                data = $random(seed) & 32'h3;    // Low thresholds let most ids through
                wb_write(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::THRESH_BASE + t), data);
                model_thresh[t] = data[2:0];
            end
            data      = $random(seed);
            ext_irq_i = data[4:0];
            repeat (2) @(posedge clk_i);
            #1;
            latch_pending(ext_irq_i);
            for (int t = 0; t < 2; t++) begin
                check_value($sformatf("irq_o[%0d]", t), 32'(irq_o[t]),
                            32'(expected_claim(t) != 3'd0));
            end
            for (int t = 0; t < 2; t++) begin
                claim_and_check(t, id);
                wb_read(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::PENDING_IDX), rd);
                check_value("pending after claim", rd, 32'(model_pending));
                if (id != 3'd0) begin
                    claim_and_check(t, id2);    // Claimed id stays out until complete
                    complete_id(t, id);
                    if (id2 != 3'd0) begin
                        complete_id(t, id2);
                    end
                    wb_read(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::PENDING_IDX), rd);
                    check_value("pending after complete", rd, 32'(model_pending));
                end
            end
        end
        report_test(4, "arbitration and claim", errs);

        // ----------------------------------------------------------
        // Timer channel 0 as id 1
        // ----------------------------------------------------------
        errs      = fail_count;
        ext_irq_i = '0;
        data      = $random(seed);
        model_prio[1]   = 3'(data[1:0]) + 3'd1;
        model_enable[0] = 8'h02;
        model_thresh[0] = 3'd0;
        wb_write(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::PRIO_BASE + 1), 32'(model_prio[1]));
        wb_write(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::ENABLE_BASE), 32'h2);
        wb_write(reg_addr(periph_pkg::REGION_PLIC, periph_pkg::THRESH_BASE), 32'h0);
        wb_write(reg_addr(periph_pkg::REGION_TMR, periph_pkg::TMR_CMP_BASE), 32'd3 + data[3:2]);
        wb_write(reg_addr(periph_pkg::REGION_TMR, periph_pkg::TMR_CTRL_IDX), 32'h1);
        waited = 0;
        rd     = '0;
        while (!rd[0] && waited < 50) begin
            wb_read(reg_addr(periph_pkg::REGION_TMR, periph_pkg::TMR_STATUS_IDX), rd);
            waited++;
        end
        if (!rd[0]) begin
            $display("Timeout at %0t: timer channel 0 never reached its compare value", $time);
            fail_count++;
        end
        model_pending[1] = 1'b1;
        check_value("irq_o[0] from timer", 32'(irq_o[0]), 32'(expected_claim(0) != 3'd0));
        claim_and_check(0, id);
        wb_write(reg_addr(periph_pkg::REGION_TMR, periph_pkg::TMR_CTRL_IDX), 32'h0);
        wb_write(reg_addr(periph_pkg::REGION_TMR, periph_pkg::TMR_STATUS_IDX), 32'h1);
        wb_read(reg_addr(periph_pkg::REGION_TMR, periph_pkg::TMR_STATUS_IDX), rd);
        check_value("timer status after clear", rd, 32'h0);
        complete_id(0, 3'd1);
        claim_and_check(0, id);
        check_value("irq_o[0] after complete", 32'(irq_o[0]), 32'h0);
        report_test(5, "timer interrupt", errs);

        $display("Checks: %0d ok, %0d wrong", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+verification
design/periph_pkg.sv
design/reg_bus_if.sv
design/wb_region_decoder.sv
design/cmp_timer.sv
design/irq_gateway.sv
design/plic_targets.sv
design/periph_top.sv
verification/tb_periph.sv

// ==== run.sh ====
#!/bin/sh
# Builds the peripheral testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_periph \
    -f sources.f -o sim_periph
./obj_dir/sim_periph | tee sim.log

if grep -q "Test failed" sim.log; then
    exit 1
fi
exit 0
